// File: sources.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_control.sv
hdl/program_counter.sv
hdl/pc_next_select.sv
hdl/instruction_memory.sv
hdl/if_id_latch.sv
hdl/fetch_stage.sv
testbench/fetch_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_stage_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: sim clean

# the run counts as passed only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/fetch_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module fetch_stage_tb;

	import fetch_pkg::*;

	localparam int MAX_ROWS = 48;

	logic                        clk;
	logic                        reset;
	logic                        start;
	logic                        stall;
	logic [1:0]                  pc_src;
	logic [`DATA_WIDTH-1:0]      register_target;
	logic                        load_write;
	logic [`IMEM_ADDR_WIDTH-1:0] load_addr;
	logic [`DATA_WIDTH-1:0]      load_data;
	instr_word_u                 instruction;
	logic [`DATA_WIDTH-1:0]      pc_plus1;
	logic [`DATA_WIDTH-1:0]      pc;
	logic                        running;
	logic                        halted;

	// program image and the stimulus/expect table
	logic [`DATA_WIDTH-1:0] prog [0:`IMEM_DEPTH-1];
	logic                   row_stall [0:MAX_ROWS-1];
	logic [1:0]             row_src [0:MAX_ROWS-1];
	logic [`DATA_WIDTH-1:0] row_reg [0:MAX_ROWS-1];
	instr_word_u            exp_instr [0:MAX_ROWS-1];
	logic [`DATA_WIDTH-1:0] exp_pp1 [0:MAX_ROWS-1];
	logic [`DATA_WIDTH-1:0] exp_pc [0:MAX_ROWS-1];
	logic                   exp_halted [0:MAX_ROWS-1];
	int                     row_count;
	int                     instr_errors;
	int                     word_errors;
	int                     flag_errors;

	// expected fetch state while rows are built
	logic [`DATA_WIDTH-1:0] m_pc;
	instr_word_u            m_instr;
	logic [`DATA_WIDTH-1:0] m_pp1;
	logic                   m_halted;

	fetch_stage uut (
		.clk(clk), .reset(reset), .start(start), .stall(stall), .pc_src(pc_src),
		.register_target(register_target), .load_write(load_write),
		.load_addr(load_addr), .load_data(load_data), .instruction(instruction),
		.pc_plus1(pc_plus1), .pc(pc), .running(running), .halted(halted)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic check_instr(input instr_word_u got, input instr_word_u exp,
		input string what);
		if (got !== exp) begin
			instr_errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input logic [`DATA_WIDTH-1:0] got,
		input logic [`DATA_WIDTH-1:0] exp, input string what);
		if (got !== exp) begin
			word_errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			flag_errors++;
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////
	// table building
	////////////////////////////////////////

	task automatic restart_model();
		m_pc     = '0;
		m_instr  = `NOP_WORD;
		m_pp1    = '0;
		m_halted = 1'b0;
	endtask

	// one clock edge with these inputs and the expected state after it
	task automatic add_row(input logic st, input logic [1:0] src,
		input logic [`DATA_WIDTH-1:0] regt);
		logic [`DATA_WIDTH-1:0] target;
		instr_word_u            word;
		if (!m_halted && !st) begin
			if (src != `PC_SRC_SEQ) begin
				case (src)
					`PC_SRC_BRANCH: target = m_pp1 +
						{{16{m_instr.i_form.offset[15]}}, m_instr.i_form.offset};
					`PC_SRC_JUMP:   target = {6'd0, m_instr.j_form.target};
					default:        target = regt;
				endcase
				m_pc    = target;
				m_instr = `NOP_WORD;
				m_pp1   = '0;
			end else begin
				word    = prog[m_pc[`IMEM_ADDR_WIDTH-1:0]];
				m_instr = word;
				m_pp1   = m_pc + 1;
				if (word.i_form.opcode == `HALT_OPCODE)
					m_halted = 1'b1;
				else
					m_pc = m_pc + 1;
			end
		end
		row_stall[row_count]  = st;
		row_src[row_count]    = src;
		row_reg[row_count]    = regt;
		exp_instr[row_count]  = m_instr;
		exp_pp1[row_count]    = m_pp1;
		exp_pc[row_count]     = m_pc;
		exp_halted[row_count] = m_halted;
		row_count++;
	endtask

	task automatic apply_rows(input int first, input int last);
		for (int r = first; r < last; r++) begin
			stall           = row_stall[r];
			pc_src          = row_src[r];
			register_target = row_reg[r];
			@(posedge clk);
			#2;
			check_instr(instruction, exp_instr[r], $sformatf("row %0d instruction", r));
			check_word(pc_plus1, exp_pp1[r], $sformatf("row %0d pc_plus1", r));
			check_word(pc, exp_pc[r], $sformatf("row %0d pc", r));
			check_flag(halted, exp_halted[r], $sformatf("row %0d halted", r));
			check_flag(running, !exp_halted[r], $sformatf("row %0d running", r));
		end
		stall  = 1'b0;
		pc_src = `PC_SRC_SEQ;
	endtask

	task automatic wait_flag(input logic want_halted, input int limit, input string what);
		int cycles;
		cycles = 0;
		while ((want_halted ? halted : running) !== 1'b1 && cycles < limit) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if ((want_halted ? halted : running) !== 1'b1) begin
			$display("timeout: %s did not happen within %0d cycles", what, limit);
			$display("Testbench failed");
			$finish;
		end
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		wait_flag(1'b0, 4, "running after start");
		check_word(pc, '0, "pc after start");
		check_instr(instruction, `NOP_WORD, "instruction after start");
		check_word(pc_plus1, '0, "pc_plus1 after start");
		check_flag(halted, 1'b0, "halted after start");
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int                     a;
		int                     seg2_first;
		logic [`DATA_WIDTH-1:0] fill;
		logic [`DATA_WIDTH-1:0] reg_pick;
		logic [`DATA_WIDTH-1:0] new_word;
		clk             = 1'b0;
		reset           = 1'b1;
		start           = 1'b0;
		stall           = 1'b0;
		pc_src          = `PC_SRC_SEQ;
		register_target = '0;
		load_write      = 1'b0;
		load_addr       = '0;
		load_data       = '0;
		instr_errors    = 0;
		word_errors     = 0;
		flag_errors     = 0;
		row_count       = 0;
		reg_pick        = 32'd100 + ($urandom(14148) % 32'd100);

		// random filler words that are never a halt
		for (a = 0; a < `IMEM_DEPTH; a++) begin
			fill = $urandom;
			if (fill[31:26] == `HALT_OPCODE)
				fill[31] = 1'b0;
			prog[a] = fill;
		end
		prog[3]  = {6'h04, 5'd1, 5'd2, 16'd10};
		prog[4]  = {`HALT_OPCODE, 26'd0};
		prog[6]  = {6'h02, 26'd40};
		prog[7]  = {`HALT_OPCODE, 26'd0};
		// branch back by twelve words
		prog[16] = {6'h04, 5'd3, 5'd4, 16'hfff4};
		prog[17] = {`HALT_OPCODE, 26'd0};
		prog[42] = {`HALT_OPCODE, 26'd0};
		prog[reg_pick[`IMEM_ADDR_WIDTH-1:0] + 8'd2] = {`HALT_OPCODE, 26'd0};

		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		check_word(pc, '0, "pc after reset");
		check_instr(instruction, `NOP_WORD, "instruction after reset");
		check_word(pc_plus1, '0, "pc_plus1 after reset");
		check_flag(running, 1'b0, "running after reset");
		check_flag(halted, 1'b0, "halted after reset");

		// program load through the debug port
		for (a = 0; a < `IMEM_DEPTH; a++) begin
			load_write = 1'b1;
			load_addr  = a[`IMEM_ADDR_WIDTH-1:0];
			load_data  = prog[a];
			@(posedge clk);
			#2;
		end
		load_write = 1'b0;

		// sequential, stall, branches, jump, register, halt
		restart_model();
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b1, `PC_SRC_JUMP, reg_pick);
		add_row(1'b1, `PC_SRC_BRANCH, reg_pick);
		add_row(1'b1, `PC_SRC_REG, reg_pick);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_BRANCH, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_BRANCH, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_JUMP, '0);
		add_row(1'b1, `PC_SRC_BRANCH, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_REG, reg_pick);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_JUMP, '0);

		pulse_start();
		apply_rows(0, row_count);
		wait_flag(1'b1, 4, "halt after the halt word");
		check_flag(running, 1'b0, "running while halted");

		// reload word 0 while halted, then restart from 0
		new_word   = prog[0] ^ 32'h0055_aa55;
		load_write = 1'b1;
		load_addr  = '0;
		load_data  = new_word;
		@(posedge clk);
		#2;
		load_write = 1'b0;
		prog[0]    = new_word;
		check_flag(halted, 1'b1, "halted during reload");

		seg2_first = row_count;
		restart_model();
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		add_row(1'b0, `PC_SRC_SEQ, '0);
		pulse_start();
		// debug writes while running must not reach memory
		load_write = 1'b1;
		load_addr  = 8'd2;
		load_data  = ~prog[2];
		apply_rows(seg2_first, row_count);
		load_write = 1'b0;

		$display("errors: instruction %0d, word %0d, flag %0d",
			instr_errors, word_errors, flag_errors);
		if (instr_errors + word_errors + flag_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module fetch_stage (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        start,
	input  wire                        stall,
	input  wire [1:0]                  pc_src,
	input  wire [`DATA_WIDTH-1:0]      register_target,
	input  wire                        load_write,
	input  wire [`IMEM_ADDR_WIDTH-1:0] load_addr,
	input  wire [`DATA_WIDTH-1:0]      load_data,
	output fetch_pkg::instr_word_u     instruction,
	output logic [`DATA_WIDTH-1:0]     pc_plus1,
	output logic [`DATA_WIDTH-1:0]     pc,
	output logic                       running,
	output logic                       halted
);

	import fetch_pkg::*;

	wire [`DATA_WIDTH-1:0] pc_incr;
	wire [`DATA_WIDTH-1:0] next_pc;
	wire instr_word_u      fetched;
	wire                   pc_enable;
	wire                   pc_clear;
	wire                   latch_enable;
	wire                   latch_clear;
	wire                   mem_write;
	wire                   debug_select;

	////////////////////////////////////////
	// control
	////////////////////////////////////////

	fetch_control u_control (
		.clk(clk), .reset(reset), .start(start), .stall(stall),
		.pc_src(pc_src), .load_write(load_write), .fetched(fetched),
		.pc_enable(pc_enable), .pc_clear(pc_clear),
		.latch_enable(latch_enable), .latch_clear(latch_clear),
		.mem_write(mem_write), .debug_select(debug_select),
		.running(running), .halted(halted)
	);

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////

	program_counter u_pc (
		.clk(clk), .reset(reset), .clear(pc_clear), .enable(pc_enable),
		.next_pc(next_pc), .pc(pc), .pc_incr(pc_incr)
	);

	// targets come from the word already in the latch
	pc_next_select u_pc_mux (
		.pc_src(pc_src), .pc_incr(pc_incr), .latched_instr(instruction),
		.latched_pc_plus1(pc_plus1), .register_target(register_target),
		.next_pc(next_pc)
	);

	instruction_memory u_imem (
		.clk(clk), .write(mem_write), .debug_select(debug_select), .pc(pc),
		.load_addr(load_addr), .load_data(load_data), .data(fetched)
	);

	if_id_latch u_if_id (
		.clk(clk), .reset(reset), .enable(latch_enable), .clear(latch_clear),
		.instr_in(fetched), .pc_plus1_in(pc_incr),
		.instr_out(instruction), .pc_plus1_out(pc_plus1)
	);

endmodule

`default_nettype wire

// File: hdl/if_id_latch.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module if_id_latch (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         enable,
	input  wire                         clear,
	input  wire fetch_pkg::instr_word_u instr_in,
	input  wire [`DATA_WIDTH-1:0]       pc_plus1_in,
	output fetch_pkg::instr_word_u      instr_out,
	output logic [`DATA_WIDTH-1:0]      pc_plus1_out
);

	////////////////////////////////////////
	// IF/ID register
	////////////////////////////////////////

	// clear beats enable so a redirect always drops the word
	always_ff @(posedge clk) begin
		if (reset || clear) begin
			instr_out    <= `NOP_WORD;
			pc_plus1_out <= '0;
		end else if (enable) begin
			instr_out    <= instr_in;
			pc_plus1_out <= pc_plus1_in;
		end
	end

	// otherwise hold, which covers a stall

endmodule

`default_nettype wire

// File: hdl/instruction_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module instruction_memory (
	input  wire                         clk,
	input  wire                         write,
	input  wire                         debug_select,
	input  wire [`DATA_WIDTH-1:0]       pc,
	input  wire [`IMEM_ADDR_WIDTH-1:0]  load_addr,
	input  wire [`DATA_WIDTH-1:0]       load_data,
	output fetch_pkg::instr_word_u      data
);

	logic [`DATA_WIDTH-1:0]      mem [0:`IMEM_DEPTH-1];
	logic [`IMEM_ADDR_WIDTH-1:0] read_addr;

	////////////////////////////////////////
	// debug write port
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (write)
			mem[load_addr] <= load_data;
	end

	// debug address wins while fetch is stopped
	assign read_addr = debug_select ? load_addr : pc[`IMEM_ADDR_WIDTH-1:0];

	// asynchronous read, word available in the same cycle
	assign data = mem[read_addr];

endmodule

`default_nettype wire

// File: hdl/pc_next_select.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module pc_next_select (
	input  wire [1:0]                   pc_src,
	input  wire [`DATA_WIDTH-1:0]       pc_incr,
	input  wire fetch_pkg::instr_word_u latched_instr,
	input  wire [`DATA_WIDTH-1:0]       latched_pc_plus1,
	input  wire [`DATA_WIDTH-1:0]       register_target,
	output logic [`DATA_WIDTH-1:0]      next_pc
);

	logic [`DATA_WIDTH-1:0] offset_ext;
	logic [`DATA_WIDTH-1:0] branch_target;
	logic [`DATA_WIDTH-1:0] jump_target;

	////////////////////////////////////////
	// target decode from the latched word
	////////////////////////////////////////

	// signed word offset, relative to the branch's pc plus one
	assign offset_ext = {{(`DATA_WIDTH-16){latched_instr.i_form.offset[15]}},
		latched_instr.i_form.offset};
	assign branch_target = latched_pc_plus1 + offset_ext;

	// absolute target, upper bits zero
	assign jump_target = {{(`DATA_WIDTH-26){1'b0}}, latched_instr.j_form.target};

	always_comb begin
		case (pc_src)
			`PC_SRC_BRANCH: next_pc = branch_target;
			`PC_SRC_JUMP:   next_pc = jump_target;
			`PC_SRC_REG:    next_pc = register_target;
			default:        next_pc = pc_incr;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/program_counter.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module program_counter (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    clear,
	input  wire                    enable,
	input  wire [`DATA_WIDTH-1:0]  next_pc,
	output logic [`DATA_WIDTH-1:0] pc,
	output logic [`DATA_WIDTH-1:0] pc_incr
);

	localparam logic [`DATA_WIDTH-1:0] WORD_STEP = 1;

	////////////////////////////////////////
	// fetch address register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || clear) begin
			pc <= '0;
		end else if (enable) begin
			pc <= next_pc;
		end
	end

	// word addressed, so one step per instruction
	assign pc_incr = pc + WORD_STEP;

endmodule

`default_nettype wire

// File: hdl/fetch_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "fetch_params.svh"

module fetch_control (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    start,
	input  wire                    stall,
	input  wire [1:0]              pc_src,
	input  wire                    load_write,
	input  wire fetch_pkg::instr_word_u fetched,
	output logic                   pc_enable,
	output logic                   pc_clear,
	output logic                   latch_enable,
	output logic                   latch_clear,
	output logic                   mem_write,
	output logic                   debug_select,
	output logic                   running,
	output logic                   halted
);

	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_RUN    = 2'd1;
	localparam logic [1:0] ST_HALTED = 2'd2;

	logic [1:0] state;
	logic [1:0] state_next;
	logic       redirect;
	logic       halt_seen;
	logic       launch;

	assign redirect  = (pc_src != `PC_SRC_SEQ);
	assign halt_seen = (fetched.i_form.opcode == `HALT_OPCODE);
	// start only counts outside of run
	assign launch    = start && (state != ST_RUN);

	always_ff @(posedge clk) begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	////////////////////////////////////////
	// strobes per state
	////////////////////////////////////////

	always_comb begin
		state_next   = state;
		pc_enable    = 1'b0;
		pc_clear     = launch;
		latch_enable = 1'b0;
		latch_clear  = launch;
		if (launch) begin
			state_next = ST_RUN;
		end else if (state == ST_RUN && !stall) begin
			if (redirect) begin
				// wrong-path word dropped, even a halt
				pc_enable   = 1'b1;
				latch_clear = 1'b1;
			end else if (halt_seen) begin
				// halt word goes down the pipe, pc frozen
				latch_enable = 1'b1;
				state_next   = ST_HALTED;
			end else begin
				pc_enable    = 1'b1;
				latch_enable = 1'b1;
			end
		end
	end

	assign running      = (state == ST_RUN);
	assign halted       = (state == ST_HALTED);
	assign debug_select = !running;
	// memory loads only while fetch is stopped
	assign mem_write    = load_write && debug_select;

endmodule

`default_nettype wire

// File: hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	// immediate format, used for branches
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] offset;
	} i_form_t;

	// jump format, absolute word target
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} j_form_t;

	// one instruction word, two decodings
	typedef union packed {
		i_form_t i_form;
		j_form_t j_form;
	} instr_word_u;

endpackage

`default_nettype wire

// File: hdl/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

////////////////////////////////////////
// widths and memory size
////////////////////////////////////////

`define DATA_WIDTH 32
`define IMEM_ADDR_WIDTH 8
`define IMEM_DEPTH 256

////////////////////////////////////////
// pc source codes and special words
////////////////////////////////////////

`define PC_SRC_SEQ 2'd0
`define PC_SRC_BRANCH 2'd1
`define PC_SRC_JUMP 2'd2
`define PC_SRC_REG 2'd3

`define HALT_OPCODE 6'h3f
// bubble inserted on redirect and after reset
`define NOP_WORD {`DATA_WIDTH{1'b0}}

`endif
